//--- logic/backend_cfg.svh
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// datapath widths
`define BACKEND_XLEN 32
`define BACKEND_REG_AW 5

// forwarding network shape
`define BACKEND_PIPES 2
`define BACKEND_FWD_STAGES 3     // m1, m2, wb

// ex, m1, m2, wb
`define BACKEND_STAGES 4

`endif

//--- logic/backend_pkg.sv
`default_nettype none
`include "backend_cfg.svh"

package backend_pkg;

	typedef logic [`BACKEND_XLEN-1:0] word_t;
	typedef logic [`BACKEND_REG_AW-1:0] reg_addr_t;       // r0 means no write

	// one-hot ex source, bit 0 old value, bits 1..3 m1/m2/wb
	typedef logic [`BACKEND_FWD_STAGES:0] ex_fwd_sel_t;
	typedef logic [$clog2(`BACKEND_PIPES)-1:0] pipe_sel_t;

	typedef logic [`BACKEND_STAGES-2:0] stage_vec_t;      // ex, m1, m2
	typedef logic [`BACKEND_STAGES-1:0] revert_vec_t;     // ex .. wb

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_sll  = 4'd5,
		alu_srl  = 4'd6,
		alu_slt  = 4'd7,
		alu_link = 4'd8      // pc + 4
	} alu_op_e;

endpackage

`default_nettype wire

//--- logic/ex_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// ex stage control, registered in stage_ctrl_regs
interface ex_ctrl_if;

	logic                           valid;
	backend_pkg::alu_op_e           alu_op;
	backend_pkg::ex_fwd_sel_t [1:0] fwd_sel;    // per operand, 0 is rj
	backend_pkg::pipe_sel_t   [1:0] pipe_sel;

	modport ctrl (
		output valid,
		output alu_op,
		output fwd_sel,
		output pipe_sel
	);

	modport exec (
		input valid,
		input alu_op,
		input fwd_sel,
		input pipe_sel
	);

endinterface

`default_nettype wire

//--- logic/stage_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_cfg.svh"

module stage_ctrl_regs (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire backend_pkg::stage_vec_t          stall_vec_i,
	input  wire backend_pkg::stage_vec_t          clr_vec_i,
	input  wire                                   issue_i,
	input  wire backend_pkg::alu_op_e             alu_op_i,
	input  wire backend_pkg::reg_addr_t           w_reg_i,
	input  wire                                   revert_i,
	input  wire backend_pkg::pipe_sel_t     [1:0] pipe_sel_i,
	input  wire backend_pkg::ex_fwd_sel_t   [1:0] fwd_sel_i,
	ex_ctrl_if.ctrl                               ex_o,
	output backend_pkg::reg_addr_t                wb_reg_o,
	output backend_pkg::revert_vec_t              revert_vector_o
);

	localparam int ns = `BACKEND_STAGES;
	localparam backend_pkg::ex_fwd_sel_t sel_old = backend_pkg::ex_fwd_sel_t'(1);

	logic                              ex_valid_q;
	backend_pkg::alu_op_e              ex_op_q;
	backend_pkg::ex_fwd_sel_t [1:0]    ex_fwd_q;
	backend_pkg::pipe_sel_t   [1:0]    ex_pipe_q;
	backend_pkg::reg_addr_t   [ns-1:0] w_reg_q;     // index 0 is ex, ns-1 is wb
	logic                     [ns-1:0] revert_q;
	logic                     [ns-1:0] stall_ext;

	assign stall_ext = {1'b0, stall_vec_i};         // wb never stalls

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid_q <= 1'b0;
			ex_op_q    <= backend_pkg::alu_add;
			ex_fwd_q   <= {2{sel_old}};
			ex_pipe_q  <= '0;
			w_reg_q    <= '0;
			revert_q   <= '0;
		end else begin
			// ex stage
			if (!stall_vec_i[0]) begin
				if (issue_i) begin
					ex_valid_q  <= 1'b1;
					ex_op_q     <= alu_op_i;
					ex_fwd_q    <= fwd_sel_i;
					ex_pipe_q   <= pipe_sel_i;
					w_reg_q[0]  <= w_reg_i;
					revert_q[0] <= revert_i;
				end else begin
					ex_valid_q  <= 1'b0;  // bubble
					ex_op_q     <= backend_pkg::alu_add;
					ex_fwd_q    <= {2{sel_old}};
					ex_pipe_q   <= '0;
					w_reg_q[0]  <= '0;
					revert_q[0] <= 1'b0;
				end
			end else begin
				// operands were captured at this edge, so read them back from now on
				ex_fwd_q <= {2{sel_old}};
			end

			// m1, m2 and wb share one rule
			for (int s = 1; s < ns; s++) begin
				if (!stall_ext[s]) begin
					if (clr_vec_i[s-1] | stall_vec_i[s-1]) begin
						w_reg_q[s]  <= '0;
						revert_q[s] <= 1'b0;
					end else begin
						w_reg_q[s]  <= w_reg_q[s-1];
						revert_q[s] <= revert_q[s-1];
					end
				end
			end
		end
	end

	assign ex_o.valid    = ex_valid_q;
	assign ex_o.alu_op   = ex_op_q;
	assign ex_o.fwd_sel  = ex_fwd_q;
	assign ex_o.pipe_sel = ex_pipe_q;

	assign wb_reg_o        = w_reg_q[ns-1];
	assign revert_vector_o = revert_q;

endmodule

`default_nettype wire

//--- logic/ex_operand_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_cfg.svh"

module ex_operand_stage (
	input  wire                      clk,
	input  wire                      stall_i,        // ex stall bit
	input  wire backend_pkg::word_t  pc_i,
	input  wire backend_pkg::word_t  rj_i,
	input  wire backend_pkg::word_t  rk_i,
	input  wire backend_pkg::word_t  [`BACKEND_PIPES-1:0][`BACKEND_FWD_STAGES-1:0]
	                                 forwarding_src_i,
	ex_ctrl_if.exec                  ex_i,
	output backend_pkg::word_t       pc_o,
	output backend_pkg::word_t       op_a_o,
	output backend_pkg::word_t       op_b_o
);

	localparam int fs = `BACKEND_FWD_STAGES;

	backend_pkg::word_t       pc_q;
	backend_pkg::word_t [1:0] opnd_q;      // 0 is rj, 1 is rk
	backend_pkg::word_t [1:0] opnd_fwd;

	// one-hot select, so OR of masked sources
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			opnd_fwd[i] = {`BACKEND_XLEN{ex_i.fwd_sel[i][0]}} & opnd_q[i];
			for (int s = 0; s < fs; s++) begin
				opnd_fwd[i] = opnd_fwd[i] |
					({`BACKEND_XLEN{ex_i.fwd_sel[i][s+1]}} &
					 forwarding_src_i[ex_i.pipe_sel[i]][s]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			pc_q   <= pc_i;
			opnd_q <= {rk_i, rj_i};
		end else begin
			opnd_q <= opnd_fwd;  // keep the value seen at the stalled edge
		end
	end

	assign pc_o   = pc_q;
	assign op_a_o = opnd_fwd[0];
	assign op_b_o = opnd_fwd[1];

endmodule

`default_nettype wire

//--- logic/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_cfg.svh"

module exec_alu (
	ex_ctrl_if.exec                 ex_i,
	input  wire backend_pkg::word_t pc_i,
	input  wire backend_pkg::word_t op_a_i,
	input  wire backend_pkg::word_t op_b_i,
	output backend_pkg::word_t      result_o
);

	localparam int shamt_w = $clog2(`BACKEND_XLEN);

	backend_pkg::word_t alu_res;
	logic [shamt_w-1:0] shamt;

	assign shamt = op_b_i[shamt_w-1:0];     // low bits only

	always_comb begin
		case (ex_i.alu_op)
			backend_pkg::alu_add:  alu_res = op_a_i + op_b_i;
			backend_pkg::alu_sub:  alu_res = op_a_i - op_b_i;
			backend_pkg::alu_and:  alu_res = op_a_i & op_b_i;
			backend_pkg::alu_or:   alu_res = op_a_i | op_b_i;
			backend_pkg::alu_xor:  alu_res = op_a_i ^ op_b_i;
			backend_pkg::alu_sll:  alu_res = op_a_i << shamt;
			backend_pkg::alu_srl:  alu_res = op_a_i >> shamt;
			backend_pkg::alu_slt:  alu_res = backend_pkg::word_t'($signed(op_a_i) < $signed(op_b_i));
			backend_pkg::alu_link: alu_res = pc_i + backend_pkg::word_t'(4);
			default:               alu_res = '0;
		endcase
	end

	// bubbles carry a zero result
	assign result_o = ex_i.valid ? alu_res : '0;

endmodule

`default_nettype wire

//--- logic/result_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_cfg.svh"

module result_pipe (
	input  wire                                               clk,
	input  wire                                               rst_n,
	input  wire backend_pkg::stage_vec_t                      stall_vec_i,
	input  wire backend_pkg::word_t                           ex_result_i,
	output backend_pkg::word_t [`BACKEND_FWD_STAGES-1:0]      forwarding_data_o,
	output backend_pkg::word_t                                wb_result_o
);

	localparam int fs = `BACKEND_FWD_STAGES;

	backend_pkg::word_t [fs-1:0] res_q;     // m1, m2, wb
	logic               [fs-1:0] hold;

	// each result register follows its own stage stall
	assign hold = {1'b0, stall_vec_i[fs-1:1]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_q <= '0;
		end else begin
			if (!hold[0]) begin
				res_q[0] <= ex_result_i;
			end
			for (int s = 1; s < fs; s++) begin
				if (!hold[s]) begin
					res_q[s] <= res_q[s-1];
				end
			end
		end
	end

	assign forwarding_data_o = res_q;
	assign wb_result_o       = res_q[fs-1];

endmodule

`default_nettype wire

//--- logic/backend_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_cfg.svh"

module backend_pipe (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire backend_pkg::stage_vec_t         stall_vec_i,  // 0 ex, 1 m1, 2 m2
	input  wire backend_pkg::stage_vec_t         clr_vec_i,
	input  wire                                  issue_i,
	input  wire backend_pkg::alu_op_e            alu_op_i,
	input  wire backend_pkg::reg_addr_t          w_reg_i,
	input  wire                                  revert_i,
	input  wire backend_pkg::word_t              pc_i,
	input  wire backend_pkg::word_t              rj_i,
	input  wire backend_pkg::word_t              rk_i,
	input  wire backend_pkg::pipe_sel_t   [1:0]  pipe_sel_i,
	input  wire backend_pkg::ex_fwd_sel_t [1:0]  fwd_sel_i,
	input  wire backend_pkg::word_t [`BACKEND_PIPES-1:0][`BACKEND_FWD_STAGES-1:0]
	                                             forwarding_src_i,
	output backend_pkg::word_t [`BACKEND_FWD_STAGES-1:0] forwarding_data_o,
	output backend_pkg::reg_addr_t               reg_w_addr_o,
	output backend_pkg::word_t                   reg_w_data_o,
	output backend_pkg::revert_vec_t             revert_vector_o
);

	backend_pkg::word_t ex_pc;
	backend_pkg::word_t ex_op_a;
	backend_pkg::word_t ex_op_b;
	backend_pkg::word_t ex_result;

	ex_ctrl_if ex_ctrl ();

	stage_ctrl_regs ctrl_regs_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.stall_vec_i     (stall_vec_i),
		.clr_vec_i       (clr_vec_i),
		.issue_i         (issue_i),
		.alu_op_i        (alu_op_i),
		.w_reg_i         (w_reg_i),
		.revert_i        (revert_i),
		.pipe_sel_i      (pipe_sel_i),
		.fwd_sel_i       (fwd_sel_i),
		.ex_o            (ex_ctrl),
		.wb_reg_o        (reg_w_addr_o),
		.revert_vector_o (revert_vector_o)
	);

	ex_operand_stage operand_inst (
		.clk              (clk),
		.stall_i          (stall_vec_i[0]),
		.pc_i             (pc_i),
		.rj_i             (rj_i),
		.rk_i             (rk_i),
		.forwarding_src_i (forwarding_src_i),
		.ex_i             (ex_ctrl),
		.pc_o             (ex_pc),
		.op_a_o           (ex_op_a),
		.op_b_o           (ex_op_b)
	);

	exec_alu alu_inst (
		.ex_i     (ex_ctrl),
		.pc_i     (ex_pc),
		.op_a_i   (ex_op_a),
		.op_b_i   (ex_op_b),
		.result_o (ex_result)
	);

	// m1/m2/wb results double as forwarding sources
	result_pipe result_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.stall_vec_i       (stall_vec_i),
		.ex_result_i       (ex_result),
		.forwarding_data_o (forwarding_data_o),
		.wb_result_o       (reg_w_data_o)
	);

endmodule

`default_nettype wire

//--- verification/backend_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_cfg.svh"

module backend_pipe_tb;

	localparam int max_cycles = 400;     // the full run takes about 90
	localparam int msb = `BACKEND_XLEN - 1;
	localparam backend_pkg::ex_fwd_sel_t sel_old = 4'b0001;

	logic                           clk;
	logic                           rst_n;
	backend_pkg::stage_vec_t        stall_vec;
	backend_pkg::stage_vec_t        clr_vec;
	logic                           issue;
	backend_pkg::alu_op_e           alu_op;
	backend_pkg::reg_addr_t         w_reg;
	logic                           revert;
	backend_pkg::word_t             pc, rj, rk;
	backend_pkg::pipe_sel_t   [1:0] pipe_sel;
	backend_pkg::ex_fwd_sel_t [1:0] fwd_sel;
	backend_pkg::word_t [`BACKEND_PIPES-1:0][`BACKEND_FWD_STAGES-1:0] fwd_src;
	backend_pkg::word_t [`BACKEND_FWD_STAGES-1:0] fwd_data;
	backend_pkg::reg_addr_t         reg_w_addr;
	backend_pkg::word_t             reg_w_data;
	backend_pkg::revert_vec_t       revert_vector;

	logic [31:0] lfsr;
	string       cur_test;
	int          errors = 0;
	int          err_mark = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          cycles = 0;

	backend_pipe backend_pipe_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.stall_vec_i       (stall_vec),
		.clr_vec_i         (clr_vec),
		.issue_i           (issue),
		.alu_op_i          (alu_op),
		.w_reg_i           (w_reg),
		.revert_i          (revert),
		.pc_i              (pc),
		.rj_i              (rj),
		.rk_i              (rk),
		.pipe_sel_i        (pipe_sel),
		.fwd_sel_i         (fwd_sel),
		.forwarding_src_i  (fwd_src),
		.forwarding_data_o (fwd_data),
		.reg_w_addr_o      (reg_w_addr),
		.reg_w_data_o      (reg_w_data),
		.revert_vector_o   (revert_vector)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// expected result from the alu rules
	function automatic backend_pkg::word_t alu_model(input backend_pkg::alu_op_e op,
			input backend_pkg::word_t pc_v, input backend_pkg::word_t a,
			input backend_pkg::word_t b);
		backend_pkg::word_t r;
		r = '0;
		case (op)
			backend_pkg::alu_add:  r = a + b;
			backend_pkg::alu_sub:  r = a + ~b + 32'd1;   // two's complement
			backend_pkg::alu_and:  r = a & b;
			backend_pkg::alu_or:   r = a | b;
			backend_pkg::alu_xor:  r = a ^ b;
			backend_pkg::alu_sll:  r = a << b[$clog2(`BACKEND_XLEN)-1:0];
			backend_pkg::alu_srl:  r = a >> b[$clog2(`BACKEND_XLEN)-1:0];
			// differing signs decide alone, same signs keep unsigned order
			backend_pkg::alu_slt:  r[0] = (a[msb] != b[msb]) ? a[msb] : (a < b);
			backend_pkg::alu_link: r = pc_v + 32'd4;
			default:               r = '0;
		endcase
		return r;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_mark = errors;
		issue = 1'b0;
		stall_vec = '0;
		clr_vec = '0;
		revert = 1'b0;
		fwd_sel = {2{sel_old}};
		pipe_sel = '0;
	endtask

	task automatic end_test();
		if (errors == err_mark)
			$display("test %s: ok", cur_test);
		else
			$display("test %s: %0d error(s)", cur_test, errors - err_mark);
		tests_run++;
	endtask

	// issue with both selects on the registered operands
	task automatic drive_instr(input backend_pkg::alu_op_e op, input backend_pkg::reg_addr_t rd,
			input logic rev, input backend_pkg::word_t pc_v, input backend_pkg::word_t a,
			input backend_pkg::word_t b);
		issue = 1'b1;
		alu_op = op;
		w_reg = rd;
		revert = rev;
		pc = pc_v;
		rj = a;
		rk = b;
		fwd_sel = {2{sel_old}};
		pipe_sel = '0;
	endtask

	task automatic load_sources();
		for (int p = 0; p < `BACKEND_PIPES; p++)
			for (int s = 0; s < `BACKEND_FWD_STAGES; s++)
				fwd_src[p][s] = rand_bits(32);
	endtask

	task automatic test_reset();
		begin_test("reset");
		check_val("wb addr", 32'd0, 32'(reg_w_addr));
		check_val("wb data", 32'd0, reg_w_data);
		check_val("revert vector", 32'd0, 32'(revert_vector));
		end_test();
	endtask

	task automatic test_alu_ops();
		backend_pkg::alu_op_e   op;
		backend_pkg::reg_addr_t rd;
		backend_pkg::word_t     pc_v, a, b;
		begin_test("alu_ops");
		op = backend_pkg::alu_add;
		repeat (op.num()) begin
			pc_v = rand_bits(32);
			a = rand_bits(32);
			b = rand_bits(32);
			rd = backend_pkg::reg_addr_t'(rand_bits(5)) | 5'd1;
			drive_instr(op, rd, 1'b0, pc_v, a, b);
			step();
			issue = 1'b0;
			repeat (2) step();
			check_val({op.name(), " early addr"}, 32'd0, 32'(reg_w_addr));
			step();
			check_val({op.name(), " addr"}, 32'(rd), 32'(reg_w_addr));
			check_val({op.name(), " data"}, alu_model(op, pc_v, a, b), reg_w_data);
			op = op.next();
		end
		end_test();
	endtask

	task automatic test_back_to_back();
		backend_pkg::word_t res [4];
		backend_pkg::word_t a, b;
		int idx;
		begin_test("back_to_back");
		step();     // let the last write leave wb
		for (int t = 0; t <= 8; t++) begin
			// instruction idx sits in stage s at t = idx + 2 + s
			for (int s = 0; s < `BACKEND_FWD_STAGES; s++) begin
				idx = t - 2 - s;
				if (idx >= 0 && idx < 4)
					check_val("forwarding data", res[idx], fwd_data[s]);
			end
			idx = t - 4;
			if (idx >= 0 && idx < 4) begin
				check_val("wb addr", 32'(20 + idx), 32'(reg_w_addr));
				check_val("wb data", res[idx], reg_w_data);
			end else begin
				check_val("idle wb addr", 32'd0, 32'(reg_w_addr));
			end
			if (t < 4) begin
				a = rand_bits(32);
				b = rand_bits(32);
				res[t] = alu_model(backend_pkg::alu_add, '0, a, b);
				drive_instr(backend_pkg::alu_add, backend_pkg::reg_addr_t'(20 + t), 1'b0, '0, a, b);
			end else begin
				issue = 1'b0;
			end
			step();
		end
		end_test();
	endtask

	task automatic test_forwarding();
		backend_pkg::word_t exp;
		int s2;
		begin_test("forwarding");
		for (int p = 0; p < `BACKEND_PIPES; p++) begin
			for (int s = 0; s < `BACKEND_FWD_STAGES; s++) begin
				s2 = (s + 1) % `BACKEND_FWD_STAGES;   // rk takes the other pipe
				load_sources();
				drive_instr(backend_pkg::alu_sub, 5'd7, 1'b0, '0, rand_bits(32), rand_bits(32));
				fwd_sel[0] = sel_old << (s + 1);
				fwd_sel[1] = sel_old << (s2 + 1);
				pipe_sel[0] = p[0];
				pipe_sel[1] = ~p[0];
				exp = alu_model(backend_pkg::alu_sub, '0, fwd_src[p][s], fwd_src[1 - p][s2]);
				step();
				issue = 1'b0;
				repeat (3) step();
				check_val("fwd addr", 32'd7, 32'(reg_w_addr));
				check_val($sformatf("fwd data pipe %0d stage %0d", p, s), exp, reg_w_data);
			end
		end
		end_test();
	endtask

	task automatic test_ex_stall();
		backend_pkg::word_t b;
		backend_pkg::word_t exp;
		begin_test("ex_stall");
		load_sources();
		b = rand_bits(32);
		drive_instr(backend_pkg::alu_add, 5'd9, 1'b0, '0, rand_bits(32), b);
		fwd_sel[0] = sel_old << 2;     // m2 of pipe 1
		pipe_sel[0] = 1'b1;
		exp = '0;
		for (int t = 1; t <= 8; t++) begin
			step();
			if (t == 1) begin
				issue = 1'b0;
				stall_vec = 3'b001;
			end
			if (t == 2) begin
				exp = alu_model(backend_pkg::alu_add, '0, fwd_src[1][1], b);
				load_sources();          // must not reach the held operand
			end
			if (t == 4)
				stall_vec = '0;
			if (t == 7) begin
				check_val("stalled addr", 32'd9, 32'(reg_w_addr));
				check_val("stalled data", exp, reg_w_data);
			end else begin
				check_val("extra write addr", 32'd0, 32'(reg_w_addr));
			end
		end
		end_test();
	endtask

	task automatic test_clear_revert();
		begin_test("clear_revert");
		drive_instr(backend_pkg::alu_add, 5'd12, 1'b0, '0, rand_bits(32), rand_bits(32));
		for (int t = 1; t <= 6; t++) begin
			step();
			issue = 1'b0;
			clr_vec = (t == 2) ? 3'b010 : 3'b000;   // hits m1 at the next edge
			check_val("cleared addr", 32'd0, 32'(reg_w_addr));
		end
		drive_instr(backend_pkg::alu_or, 5'd13, 1'b1, '0, rand_bits(32), rand_bits(32));
		for (int t = 1; t <= 5; t++) begin
			step();
			issue = 1'b0;
			revert = 1'b0;
			check_val("revert vector", (t <= 4) ? (32'd1 << (t - 1)) : 32'd0,
				32'(revert_vector));
		end
		end_test();
	endtask

	initial begin
		lfsr = 32'h9280_fa4a;
		rst_n = 1'b0;
		issue = 1'b0;
		stall_vec = '0;
		clr_vec = '0;
		alu_op = backend_pkg::alu_add;
		w_reg = '0;
		revert = 1'b0;
		pc = '0;
		rj = '0;
		rk = '0;
		pipe_sel = '0;
		fwd_sel = {2{sel_old}};
		fwd_src = '0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;

		test_reset();
		test_alu_ops();
		test_back_to_back();
		test_forwarding();
		test_ex_stall();
		test_clear_revert();

		$display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/backend_pkg.sv
logic/ex_ctrl_if.sv
logic/stage_ctrl_regs.sv
logic/ex_operand_stage.sv
logic/exec_alu.sv
logic/result_pipe.sv
logic/backend_pipe.sv
verification/backend_pipe_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module backend_pipe_tb -o backend_sim \
	|| { echo "build failed"; exit 1; }

out="$(./obj_dir/backend_sim)"
echo "$out"

grep -q "RESULT: PASS" <<< "$out" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
